//--- commit_monitor.f
logic/monitor_pkg.sv
logic/decoded_itf.sv
logic/commit_decode.sv
logic/segment_counter.sv
logic/trace_result.sv
logic/commit_monitor.sv
test/commit_monitor_checker.sv
test/commit_monitor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=commit_monitor_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module commit_monitor_tb \
    -f commit_monitor.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG_FILE"
exit 1

//--- test/commit_monitor_tb.sv
module commit_monitor_tb import monitor_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 20;
    localparam int TEST_CYCLES = 6 + 8 + 10 + 24 + 30 + 10 + 16; // reset, then each test
    localparam int TIMEOUT     = 2 * TEST_CYCLES;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       insn;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rd_wdata;
        access_e               kind;
        logic [XLEN-1:0]       mem_addr;
        logic [XLEN-1:0]       mem_data;
    } trace_rec_t;

    logic itf, rst_n, commit_valid, halted, seg_done, trace_valid;
    logic [XLEN-1:0] commit_pc_rdata, commit_pc_wdata, commit_insn, commit_rd_wdata;
    logic [XLEN-1:0] commit_mem_addr, commit_mem_wdata;
    logic [REG_ADDR_W-1:0] commit_rd_addr, trace_rd_addr;
    logic [MASK_W-1:0] commit_mem_rmask, commit_mem_wmask;
    logic [COUNT_W-1:0] seg_insts, seg_cycles;
    logic [XLEN-1:0] trace_pc, trace_insn, trace_rd_wdata, trace_mem_addr, trace_mem_data;
    access_e trace_mem_kind;

    integer seed = 32'hf8ed;
    int cyc = 0;
    int errors = 0;
    int tests = 0;
    int test_errors0 = 0;
    string test_name = "reset";
    logic [XLEN-1:0] cur_pc;
    logic [XLEN-1:0] pc_step = 32'd4; // zero holds the pc in place
    trace_rec_t exp_q[$];
    trace_rec_t exp_rec, act_rec;

    commit_monitor dut0 (.*);

    bind commit_monitor commit_monitor_checker chk0 (
        .itf(itf), .rst_n(rst_n), .commit_valid(commit_valid),
        .halted(halted), .trace_valid(trace_valid), .seg_done(seg_done)
    );

    always #HALF_PERIOD itf = ~itf;

    always @(posedge itf) begin
        cyc++;
        if (cyc >= TIMEOUT) begin
            $display("timeout, run stopped after %0d cycles", cyc);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // reference model and scoreboard
    ////////////////////////////////////////
    function automatic trace_rec_t model_trace();
        trace_rec_t r;
        logic [MASK_W-1:0] m;
        int low;
        int nbytes;
        r.pc       = commit_pc_rdata;
        r.insn     = (commit_insn[1:0] != 2'b11) ? {16'h0, commit_insn[15:0]} : commit_insn;
        r.rd_addr  = commit_rd_addr;
        r.rd_wdata = (commit_rd_addr == 0) ? '0 : commit_rd_wdata; // x0 never written
        m = (commit_mem_wmask != 0) ? commit_mem_wmask : commit_mem_rmask;
        r.kind = (commit_mem_wmask != 0) ? ACC_STORE : ((m != 0) ? ACC_LOAD : ACC_NONE);
        low = 0;
        if (m != 0) begin
            while (!m[low]) low++;
        end
        r.mem_addr = {commit_mem_addr[XLEN-1:2], 2'b00} + 32'(low);
        r.mem_data = '0;
        if (r.kind == ACC_STORE) begin
            nbytes = $countones(commit_mem_wmask);
            if (nbytes == 3) nbytes = 0; // three lanes carry no size
            for (int b = 0; b < nbytes; b++) begin
                r.mem_data[8*b +: 8] = commit_mem_wdata[8*(low+b) +: 8];
            end
        end
        return r;
    endfunction

    always @(negedge itf) begin
        if (rst_n && trace_valid) begin
            act_rec = {trace_pc, trace_insn, trace_rd_addr, trace_rd_wdata,
                       trace_mem_kind, trace_mem_addr, trace_mem_data};
            if (exp_q.size() == 0) begin
                $display("%s: trace record at pc %h with no commit pending", test_name, trace_pc);
                errors++;
            end else begin
                exp_rec = exp_q.pop_front();
                if (act_rec !== exp_rec) begin
                    $display("mismatch %s trace expected %h actual %h", test_name, exp_rec, act_rec);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // drivers and checks
    ////////////////////////////////////////
    task automatic apply_reset();
        @(negedge itf);
        rst_n        = 1'b0;
        commit_valid = 1'b0;
        repeat (5) @(negedge itf);
        rst_n = 1'b1;
    endtask

    task automatic send(
        input logic [XLEN-1:0]       insn,
        input logic [REG_ADDR_W-1:0] rd,
        input logic [MASK_W-1:0]     rmask,
        input logic [MASK_W-1:0]     wmask,
        input logic [XLEN-1:0]       maddr,
        input bit                    traced
    );
        @(negedge itf);
        commit_valid     = 1'b1;
        commit_pc_rdata  = cur_pc;
        commit_pc_wdata  = cur_pc + pc_step;
        commit_insn      = insn;
        commit_rd_addr   = rd;
        commit_rd_wdata  = $random(seed);
        commit_mem_addr  = maddr;
        commit_mem_rmask = rmask;
        commit_mem_wmask = wmask;
        commit_mem_wdata = $random(seed);
        cur_pc           = cur_pc + 32'd4;
        if (traced) exp_q.push_back(model_trace());
    endtask

    task automatic alu(input logic [XLEN-1:0] insn, input logic [REG_ADDR_W-1:0] rd);
        send(insn, rd, '0, '0, '0, 1'b1);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge itf);
            commit_valid = 1'b0;
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        test_errors0 = errors;
    endtask

    task automatic end_test();
        int w;
        w = 0;
        while (exp_q.size() != 0 && w < 8) begin
            @(posedge itf);
            w++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d trace records never appeared", test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        tests++;
        $display("test %s finished, %0d errors", test_name, errors - test_errors0);
    endtask

    // waits for seg_done after the stop marker, then checks the counts
    task automatic check_segment(input int exp_insts, input int exp_cycles, input int stop_cyc);
        int w;
        w = 0;
        while (!seg_done && w < 8) begin
            idle(1);
            w++;
        end
        if (!seg_done) begin
            $display("%s: seg_done never pulsed after the stop marker", test_name);
            errors++;
        end else begin
            check_word("seg_done latency", 32'd2, cyc - stop_cyc);
            check_word("seg_insts", exp_insts, seg_insts);
            check_word("seg_cycles", exp_cycles, seg_cycles);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_trace_fields();
        begin_test("trace_fields");
        alu(32'h0030_8093, 5'd1);
        alu(32'h0041_0013, 5'd0);  // destination x0
        alu(32'hbeef_4529, 5'd10); // compressed, junk upper half
        alu(32'h00b5_0533, 5'd10);
        idle(1);
        end_test();
    endtask

    task automatic test_loads_stores();
        begin_test("loads_stores");
        send(32'h00a1_0123, 5'd0, 4'b0000, 4'b0100, 32'h0000_2003, 1'b1); // byte
        send(32'h00a1_1623, 5'd0, 4'b0000, 4'b1100, 32'h0000_2012, 1'b1); // half
        send(32'h00a1_2823, 5'd0, 4'b0000, 4'b1111, 32'h0000_2020, 1'b1); // word
        send(32'h0001_2583, 5'd11, 4'b0011, 4'b0000, 32'h0000_3000, 1'b1);
        send(32'h0001_4603, 5'd12, 4'b1000, 4'b0000, 32'h0000_3007, 1'b1);
        send(32'h00a1_0023, 5'd0, 4'b0000, 4'b1110, 32'h0000_2031, 1'b1); // 3 lanes
        idle(1);
        end_test();
    endtask

    task automatic test_segment();
        int start_cyc;
        int stop_cyc;
        begin_test("segment");
        alu(INSN_SEG_START, 5'd0);
        start_cyc = cyc;
        for (int i = 0; i < 5; i++) begin
            alu(32'h0010_0093 + 32'(i << 20), 5'd1);
            idle(i);
        end
        alu(INSN_SEG_STOP, 5'd0);
        stop_cyc = cyc;
        check_segment(6, stop_cyc - start_cyc, stop_cyc);
        end_test();
    endtask

    task automatic test_restart_stray();
        int start_cyc;
        int stop_cyc;
        bit stray_done;
        begin_test("restart_stray");
        alu(INSN_SEG_START, 5'd0);
        repeat (3) begin
            alu(32'h0020_8113, 5'd2);
            idle(2);
        end
        alu(INSN_SEG_START, 5'd0); // restart drops the counts so far
        start_cyc = cyc;
        alu(32'h0030_8193, 5'd3);
        idle(1);
        alu(32'h0040_8213, 5'd4);
        alu(INSN_SEG_STOP, 5'd0);
        stop_cyc = cyc;
        check_segment(3, stop_cyc - start_cyc, stop_cyc);
        alu(INSN_SEG_STOP, 5'd0); // stray, segment is idle
        stray_done = 1'b0;
        repeat (6) begin
            idle(1);
            if (seg_done) stray_done = 1'b1;
        end
        if (stray_done) begin
            $display("%s: seg_done pulsed for a stop marker outside a segment", test_name);
            errors++;
        end
        check_word("seg_insts held", 32'd3, seg_insts);
        end_test();
    endtask

    task automatic test_halt_insn();
        begin_test("halt_insn");
        alu(32'h0050_8293, 5'd5);
        alu(INSN_HALT_SLTI, 5'd0);
        check_word("halted early", 32'd0, halted);
        send(32'h0060_8313, 5'd6, '0, '0, '0, 1'b0);
        check_word("halted", 32'd1, halted);
        send(32'h0070_8393, 5'd7, '0, '0, '0, 1'b0);
        idle(4);
        end_test();
    endtask

    task automatic test_halt_pc();
        begin_test("halt_pc");
        apply_reset();
        check_word("halted after reset", 32'd0, halted);
        alu(32'h0080_8413, 5'd8);
        alu(32'h0090_8493, 5'd9);
        pc_step = '0; // pc stuck
        alu(32'h00a0_8513, 5'd10); // halting commit still traced
        pc_step = 32'd4;
        check_word("halted early", 32'd0, halted);
        send(32'h00b0_8593, 5'd11, '0, '0, '0, 1'b0);
        check_word("halted", 32'd1, halted);
        idle(4);
        end_test();
    endtask

    initial begin
        itf              = 1'b1;
        rst_n            = 1'b0;
        commit_valid     = 1'b0;
        commit_pc_rdata  = '0;
        commit_pc_wdata  = '0;
        commit_insn      = '0;
        commit_rd_addr   = '0;
        commit_rd_wdata  = '0;
        commit_mem_addr  = '0;
        commit_mem_rmask = '0;
        commit_mem_wmask = '0;
        commit_mem_wdata = '0;
        cur_pc           = 32'h0000_1000;
        apply_reset();
        test_trace_fields();
        test_loads_stores();
        test_segment();
        test_restart_stray();
        test_halt_insn();
        test_halt_pc();
        errors += dut0.chk0.failures;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- test/commit_monitor_checker.sv
module commit_monitor_checker (
    input logic itf,
    input logic rst_n,
    input logic commit_valid,
    input logic halted,
    input logic trace_valid,
    input logic seg_done
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;  // read by the testbench at the end

    ////////////////////////////////////////
    // control outputs
    ////////////////////////////////////////
    reset_clears: assert property (@(posedge itf)
        !rst_n |=> !halted && !trace_valid && !seg_done)
        else begin
            failures++;
            $error("control outputs not low after reset");
        end

    halt_sticky: assert property (@(posedge itf) disable iff (!rst_n)
        halted |=> halted)
        else begin
            failures++;
            $error("halted fell without a reset");
        end

    ////////////////////////////////////////
    // trace timing
    ////////////////////////////////////////
    trace_follows: assert property (@(posedge itf) disable iff (!rst_n)
        commit_valid && !halted |=> ##1 trace_valid)
        else begin
            failures++;
            $error("no trace record 2 cycles after an accepted commit");
        end

    trace_has_commit: assert property (@(posedge itf) disable iff (!rst_n)
        trace_valid |-> $past(commit_valid && !halted, 2))
        else begin
            failures++;
            $error("trace record without an accepted commit 2 cycles earlier");
        end

endmodule

//--- logic/commit_monitor.sv
module commit_monitor import monitor_pkg::*; (
    input  logic                  itf,
    input  logic                  rst_n,

    // commit channel
    input  logic                  commit_valid,
    input  logic [XLEN-1:0]       commit_pc_rdata,
    input  logic [XLEN-1:0]       commit_pc_wdata,
    input  logic [XLEN-1:0]       commit_insn,
    input  logic [REG_ADDR_W-1:0] commit_rd_addr,
    input  logic [XLEN-1:0]       commit_rd_wdata,
    input  logic [XLEN-1:0]       commit_mem_addr,
    input  logic [MASK_W-1:0]     commit_mem_rmask,
    input  logic [MASK_W-1:0]     commit_mem_wmask,
    input  logic [XLEN-1:0]       commit_mem_wdata,

    output logic                  halted,

    // segment results
    output logic                  seg_done,
    output logic [COUNT_W-1:0]    seg_insts,
    output logic [COUNT_W-1:0]    seg_cycles,

    // trace record
    output logic                  trace_valid,
    output logic [XLEN-1:0]       trace_pc,
    output logic [XLEN-1:0]       trace_insn,
    output logic [REG_ADDR_W-1:0] trace_rd_addr,
    output logic [XLEN-1:0]       trace_rd_wdata,
    output access_e               trace_mem_kind,
    output logic [XLEN-1:0]       trace_mem_addr,
    output logic [XLEN-1:0]       trace_mem_data
);

    decoded_itf dec_bus ();

    commit_decode u_decode (
        .itf              (itf),
        .rst_n            (rst_n),
        .commit_valid     (commit_valid),
        .commit_pc_rdata  (commit_pc_rdata),
        .commit_pc_wdata  (commit_pc_wdata),
        .commit_insn      (commit_insn),
        .commit_rd_addr   (commit_rd_addr),
        .commit_rd_wdata  (commit_rd_wdata),
        .commit_mem_addr  (commit_mem_addr),
        .commit_mem_rmask (commit_mem_rmask),
        .commit_mem_wmask (commit_mem_wmask),
        .commit_mem_wdata (commit_mem_wdata),
        .halted           (halted),
        .dec              (dec_bus.decode)
    );

    segment_counter u_segment (
        .itf        (itf),
        .rst_n      (rst_n),
        .dec        (dec_bus.count),
        .seg_done   (seg_done),
        .seg_insts  (seg_insts),
        .seg_cycles (seg_cycles)
    );

    trace_result u_trace (
        .itf            (itf),
        .rst_n          (rst_n),
        .dec            (dec_bus.trace),
        .trace_valid    (trace_valid),
        .trace_pc       (trace_pc),
        .trace_insn     (trace_insn),
        .trace_rd_addr  (trace_rd_addr),
        .trace_rd_wdata (trace_rd_wdata),
        .trace_mem_kind (trace_mem_kind),
        .trace_mem_addr (trace_mem_addr),
        .trace_mem_data (trace_mem_data)
    );

endmodule

//--- logic/trace_result.sv
module trace_result import monitor_pkg::*; (
    input  logic                  itf,
    input  logic                  rst_n,
    decoded_itf.trace             dec,
    output logic                  trace_valid,
    output logic [XLEN-1:0]       trace_pc,
    output logic [XLEN-1:0]       trace_insn,
    output logic [REG_ADDR_W-1:0] trace_rd_addr,
    output logic [XLEN-1:0]       trace_rd_wdata,
    output access_e               trace_mem_kind,
    output logic [XLEN-1:0]       trace_mem_addr,
    output logic [XLEN-1:0]       trace_mem_data
);

    logic [XLEN-1:0] lane_data;
    logic [XLEN-1:0] mem_data_n;

    ////////////////////////////////////////
    // store data extraction
    ////////////////////////////////////////
    always_comb begin
        lane_data = dec.mem_wdata >> {dec.mem_addr[1:0], 3'b000}; // lowest lane to bit 0
        mem_data_n = '0;
        if (dec.access == ACC_STORE) begin
            case (dec.size)
                SZ_BYTE: mem_data_n = {24'h0, lane_data[7:0]};
                SZ_HALF: mem_data_n = {16'h0, lane_data[15:0]};
                SZ_WORD: mem_data_n = lane_data;
                default: mem_data_n = '0;
            endcase
        end
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= dec.dvalid;
        end
    end

    always_ff @(posedge itf) begin
        if (dec.dvalid) begin
            trace_pc       <= dec.pc;
            trace_insn     <= dec.insn;
            trace_rd_addr  <= dec.rd_addr;
            trace_rd_wdata <= dec.rd_wdata;
            trace_mem_kind <= dec.access;
            trace_mem_addr <= dec.mem_addr;
            trace_mem_data <= mem_data_n;
        end
    end

endmodule

//--- logic/segment_counter.sv
module segment_counter import monitor_pkg::*; (
    input  logic               itf,
    input  logic               rst_n,
    decoded_itf.count          dec,
    output logic               seg_done,
    output logic [COUNT_W-1:0] seg_insts,
    output logic [COUNT_W-1:0] seg_cycles
);

    seg_state_e         state;
    logic [COUNT_W-1:0] inst_cnt;
    logic [COUNT_W-1:0] cycle_cnt;
    logic               start_hit;
    logic               stop_hit;

    always_comb begin
        start_hit = dec.dvalid && (dec.marker == MARK_SEG_START);
        stop_hit  = dec.dvalid && (dec.marker == MARK_SEG_STOP) && (state == SEG_RUN);
    end

    ////////////////////////////////////////
    // segment FSM and counters
    ////////////////////////////////////////
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            state      <= SEG_IDLE;
            inst_cnt   <= '0;
            cycle_cnt  <= '0;
            seg_done   <= 1'b0;
            seg_insts  <= '0;
            seg_cycles <= '0;
        end else begin
            seg_done  <= 1'b0;
            cycle_cnt <= cycle_cnt + 1'b1;
            if (dec.dvalid) inst_cnt <= inst_cnt + 1'b1;

            if (start_hit) begin
                state     <= SEG_RUN;   // restarts an open segment too
                inst_cnt  <= '0;        // marker itself not counted
                cycle_cnt <= '0;
            end else if (stop_hit) begin
                state      <= SEG_IDLE;
                seg_done   <= 1'b1;
                seg_insts  <= inst_cnt + 1'b1;  // stop marker counts
                seg_cycles <= cycle_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/commit_decode.sv
module commit_decode import monitor_pkg::*; (
    input  logic                  itf,
    input  logic                  rst_n,
    input  logic                  commit_valid,
    input  logic [XLEN-1:0]       commit_pc_rdata,
    input  logic [XLEN-1:0]       commit_pc_wdata,
    input  logic [XLEN-1:0]       commit_insn,
    input  logic [REG_ADDR_W-1:0] commit_rd_addr,
    input  logic [XLEN-1:0]       commit_rd_wdata,
    input  logic [XLEN-1:0]       commit_mem_addr,
    input  logic [MASK_W-1:0]     commit_mem_rmask,
    input  logic [MASK_W-1:0]     commit_mem_wmask,
    input  logic [XLEN-1:0]       commit_mem_wdata,
    output logic                  halted,
    decoded_itf.decode            dec
);

    // index of the lowest set lane, zero for an empty mask
    function automatic logic [$clog2(MASK_W)-1:0] low_lane(input logic [MASK_W-1:0] mask);
        logic [$clog2(MASK_W)-1:0] idx;
        idx = '0;
        for (int i = MASK_W - 1; i >= 0; i--) begin
            if (mask[i]) idx = i[$clog2(MASK_W)-1:0];
        end
        return idx;
    endfunction

    logic            accept;
    logic            is_halt;
    logic [MASK_W-1:0] act_mask;
    marker_e         marker_n;
    access_e         access_n;
    size_e           size_n;
    logic [XLEN-1:0] insn_n;
    logic [XLEN-1:0] rd_wdata_n;
    logic [XLEN-1:0] mem_addr_n;

    ////////////////////////////////////////
    // classify
    ////////////////////////////////////////
    always_comb begin
        accept  = commit_valid && !halted; // nothing passes once halted
        is_halt = (commit_pc_rdata == commit_pc_wdata) ||
                  (commit_insn == INSN_HALT_BEQ) ||
                  (commit_insn == INSN_HALT_JAL) ||
                  (commit_insn == INSN_HALT_SLTI);

        if (commit_insn == INSN_SEG_START)     marker_n = MARK_SEG_START;
        else if (commit_insn == INSN_SEG_STOP) marker_n = MARK_SEG_STOP;
        else                                   marker_n = MARK_NONE;

        if (|commit_mem_wmask) begin
            access_n = ACC_STORE;
            act_mask = commit_mem_wmask;
        end else if (|commit_mem_rmask) begin
            access_n = ACC_LOAD;
            act_mask = commit_mem_rmask;
        end else begin
            access_n = ACC_NONE;
            act_mask = '0;
        end

        case ($countones(commit_mem_wmask))
            1:       size_n = SZ_BYTE;
            2:       size_n = SZ_HALF;
            4:       size_n = SZ_WORD;
            default: size_n = SZ_NONE; // odd lane counts have no size
        endcase

        mem_addr_n = {commit_mem_addr[XLEN-1:2], 2'b00} + XLEN'(low_lane(act_mask));
        insn_n     = (commit_insn[1:0] == 2'b11) ? commit_insn : {16'h0, commit_insn[15:0]};
        rd_wdata_n = (commit_rd_addr == '0) ? '0 : commit_rd_wdata;
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            halted     <= 1'b0;
            dec.dvalid <= 1'b0;
        end else begin
            dec.dvalid <= accept;
            if (accept && is_halt) halted <= 1'b1; // sticky until reset
        end
    end

    always_ff @(posedge itf) begin
        if (accept) begin
            dec.marker    <= marker_n;
            dec.pc        <= commit_pc_rdata;
            dec.insn      <= insn_n;
            dec.rd_addr   <= commit_rd_addr;
            dec.rd_wdata  <= rd_wdata_n;
            dec.access    <= access_n;
            dec.size      <= size_n;
            dec.mem_addr  <= mem_addr_n;
            dec.mem_wdata <= commit_mem_wdata;
        end
    end

endmodule

//--- logic/decoded_itf.sv
interface decoded_itf import monitor_pkg::*; ();

    logic                  dvalid;    // one-cycle strobe
    marker_e               marker;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;      // upper half cleared when compressed
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    access_e               access;
    size_e                 size;
    logic [XLEN-1:0]       mem_addr;  // byte address of lowest lane
    logic [XLEN-1:0]       mem_wdata;

    modport decode (
        output dvalid, marker, pc, insn, rd_addr, rd_wdata,
               access, size, mem_addr, mem_wdata
    );

    modport count (
        input dvalid, marker
    );

    modport trace (
        input dvalid, pc, insn, rd_addr, rd_wdata,
              access, size, mem_addr, mem_wdata
    );

endinterface

//--- logic/monitor_pkg.sv
package monitor_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MASK_W     = 4;  // byte lanes per word
    localparam int COUNT_W    = 32;

    ////////////////////////////////////////
    // instruction words
    ////////////////////////////////////////
    localparam logic [XLEN-1:0] INSN_HALT_BEQ  = 32'h0000_0063; // beq x0, x0, 0
    localparam logic [XLEN-1:0] INSN_HALT_JAL  = 32'h0000_006f; // jal x0, 0
    localparam logic [XLEN-1:0] INSN_HALT_SLTI = 32'hf000_2013; // slti x0 halt marker
    localparam logic [XLEN-1:0] INSN_SEG_START = 32'h0010_2013;
    localparam logic [XLEN-1:0] INSN_SEG_STOP  = 32'h0020_2013;

    typedef enum logic [1:0] {
        MARK_NONE,
        MARK_SEG_START,
        MARK_SEG_STOP
    } marker_e;

    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_LOAD,
        ACC_STORE
    } access_e;

    typedef enum logic [1:0] {
        SZ_NONE,
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } size_e;

    typedef enum logic {
        SEG_IDLE,
        SEG_RUN
    } seg_state_e;

endpackage
